//--- rtl/smc_mac_pkg.sv
// smc multiple access types
package smc_mac_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int WORD_W = 32;              // internal ahb word
  localparam int BYTE_W = 8;               // external memory bus
  localparam int LANES  = WORD_W / BYTE_W; // byte lanes per word

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BYTE_W-1:0] byte_t;

  // ahb transfer size, code 3 reserved
  typedef enum logic [1:0] {
    xsiz_8  = 2'd0,
    xsiz_16 = 2'd1,
    xsiz_32 = 2'd2
  } xfer_size_t;

  localparam logic [1:0] XSIZ_RSVD = 2'b11; // never legal on the bus

  // accesses left after the current one
  typedef logic [1:0] access_cnt_t;

  localparam access_cnt_t CNT_BYTE = 2'd0; // one access
  localparam access_cnt_t CNT_HALF = 2'd1; // two accesses
  localparam access_cnt_t CNT_WORD = 2'd3; // four accesses

  // sequencer next state, one-hot
  typedef enum logic [4:0] {
    smc_idle  = 5'b00001,
    smc_le    = 5'b00010,
    smc_rw    = 5'b00100,
    smc_store = 5'b01000,
    smc_float = 5'b10000
  } smc_state_t;

  // control shared by both datapaths
  typedef struct packed {
    xfer_size_t  xfer_size;  // stored size
    access_cnt_t num_access; // current count
  } access_ctl_t;

endpackage

//--- rtl/mac_control.sv
// multiple access control
`timescale 1ns/1ps

module mac_control (
  input  logic                      sys_clk15,
  input  logic                      n_sys_reset15,
  input  logic                      valid_access,  // address cycle of new transfer
  input  smc_mac_pkg::xfer_size_t   xfer_size,     // valid with valid_access
  input  logic                      smc_done,      // end of one external access
  input  smc_mac_pkg::smc_state_t   smc_nextstate, // from sequencer
  output smc_mac_pkg::access_ctl_t  acc_ctl,
  output logic                      mac_done,      // last access of transfer
  output smc_mac_pkg::xfer_size_t   v_xfer_size
);

  import smc_mac_pkg::*;

  xfer_size_t  r_xfer_size;  // size held for the whole transfer
  access_cnt_t r_num_access; // accesses still to go
  access_cnt_t load_cnt;     // count picked from new size
  logic        dec_en;       // qualified access end

  // ------------------------------
  // transfer size store
  // ------------------------------
  always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
  begin
    if (!n_sys_reset15)
      r_xfer_size <= xsiz_8;
    else if (valid_access)
      r_xfer_size <= xfer_size; // sampled in address cycle
  end

  // live size during the address cycle, stored one after
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  // number of extra accesses for an 8-bit bus
  always_comb
  begin
    case (xfer_size)
      xsiz_16: load_cnt = CNT_HALF;
      xsiz_32: load_cnt = CNT_WORD;
      default: load_cnt = CNT_BYTE; // byte, reserved code
    endcase
  end

  // ------------------------------
  // access counter
  // ------------------------------
  // store and idle mean the sequencer is not starting another access
  assign dec_en = smc_done && (smc_nextstate != smc_store) &&
                  (smc_nextstate != smc_idle);

  always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
  begin
    if (!n_sys_reset15)
      r_num_access <= '0;
    else if (valid_access)
      r_num_access <= load_cnt;            // new transfer wins
    else if (dec_en)
      r_num_access <= r_num_access - 2'd1; // next byte
  end

  // last access detect
  assign mac_done = (r_num_access == '0);

  assign acc_ctl = '{xfer_size: r_xfer_size, num_access: r_num_access};

  // ------------------------------
  // checks
  // ------------------------------
  // sequencer must stop after the last access of a transfer
  a_no_underflow: assert property (
    @(posedge sys_clk15) disable iff (!n_sys_reset15)
    (dec_en && !valid_access) |-> (r_num_access != '0)
  ) else $error("access counter decremented from zero");

  // bus master never issues the reserved size
  a_no_rsvd_size: assert property (
    @(posedge sys_clk15) disable iff (!n_sys_reset15)
    valid_access |-> (2'(xfer_size) != XSIZ_RSVD)
  ) else $error("reserved transfer size at address cycle");

endmodule

//--- rtl/read_assembly.sv
// read data assembly
`timescale 1ns/1ps

module read_assembly (
  input  logic                     sys_clk15,
  input  logic                     n_sys_reset15,
  input  smc_mac_pkg::access_ctl_t acc_ctl,    // size and count
  input  logic                     latch_data, // data_smc valid this cycle
  input  smc_mac_pkg::byte_t       data_smc,   // external read byte
  output smc_mac_pkg::word_t       read_data   // to internal bus
);

  import smc_mac_pkg::*;

  word_t hold_q; // bytes gathered so far
  byte_t half_hi; // upper byte of a halfword
  byte_t low_b;  // lowest lane, live or held

  // ------------------------------
  // holding register
  // ------------------------------
  // first byte read is the most significant one, count
  // before the edge picks its lane
  always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
  begin
    if (!n_sys_reset15)
    begin
      hold_q <= '0;
    end
    else if (latch_data)
    begin
      case (acc_ctl.num_access)
        2'd3:
        begin
          hold_q[31:24] <= data_smc; // first of four
          hold_q[23:0]  <= '0;
        end
        2'd2:
        begin
          hold_q[23:16] <= data_smc;
          hold_q[15:0]  <= '0;       // upper byte kept
        end
        2'd1:
        begin
          hold_q[15:8] <= data_smc;  // first of two, or third of four
          hold_q[7:0]  <= '0;
        end
        default:
        begin
          hold_q[7:0] <= data_smc;   // last access
        end
      endcase
    end
  end

  // ------------------------------
  // read mux
  // ------------------------------
  // last byte is passed straight through while it is latched,
  // so the bus sees the full value in that cycle
  assign low_b   = latch_data ? data_smc : hold_q[7:0];
  assign half_hi = hold_q[15:8];

  always_comb
  begin
    case (acc_ctl.xfer_size)
      xsiz_32:
      begin
        if (latch_data)
          read_data = {hold_q[31:8], data_smc}; // live byte in low lane
        else
          read_data = hold_q;
      end
      xsiz_16:
      begin
        if (latch_data)
          read_data = {2{half_hi, data_smc}};    // halfword in both halves
        else
          read_data = {2{hold_q[15:0]}};
      end
      default:
      begin
        read_data = {LANES{low_b}};             // byte in every lane
      end
    endcase
  end

  // ------------------------------
  // checks
  // ------------------------------
  // an unknown strobe would corrupt the held word silently
  a_latch_known: assert property (
    @(posedge sys_clk15) disable iff (!n_sys_reset15)
    !$isunknown(latch_data)
  ) else $error("latch_data unknown");

endmodule

//--- rtl/write_lane_select.sv
// write byte steering
`timescale 1ns/1ps

module write_lane_select (
  input  smc_mac_pkg::access_ctl_t acc_ctl,    // count picks the lane
  input  smc_mac_pkg::word_t       write_data, // held by ahb for whole transfer
  output smc_mac_pkg::byte_t       smc_data    // to external bus
);

  import smc_mac_pkg::*;

  // ------------------------------
  // lane select
  // ------------------------------
  // msb first, count runs down towards the low lane
  always_comb
  begin
    case (acc_ctl.num_access)
      2'd3:
      begin
        smc_data = write_data[31:24]; // first of four
      end
      2'd2:
      begin
        smc_data = write_data[23:16];
      end
      2'd1:
      begin
        smc_data = write_data[15:8];  // first of two
      end
      default:
      begin
        smc_data = write_data[BYTE_W-1:0]; // single byte or last access
      end
    endcase
  end

endmodule

//--- rtl/smc_mac_top.sv
// smc multiple access controller
`timescale 1ns/1ps

module smc_mac_top (
  input  logic                     sys_clk15,
  input  logic                     n_sys_reset15,
  input  logic                     valid_access,  // address cycle strobe
  input  smc_mac_pkg::xfer_size_t  xfer_size,
  input  logic                     smc_done,      // end of one access
  input  smc_mac_pkg::smc_state_t  smc_nextstate, // sequencer next state
  input  logic                     latch_data,    // read byte valid
  input  smc_mac_pkg::byte_t       data_smc,      // external read data
  input  smc_mac_pkg::word_t       write_data,    // internal write data
  output smc_mac_pkg::access_cnt_t r_num_access,  // access counter
  output logic                     mac_done,      // last access
  output smc_mac_pkg::xfer_size_t  v_xfer_size,
  output smc_mac_pkg::word_t       read_data,     // to internal bus
  output smc_mac_pkg::byte_t       smc_data       // to external bus
);

  import smc_mac_pkg::*;

  access_ctl_t acc_ctl; // size and count to both datapaths

  // ------------------------------
  // control
  // ------------------------------
  mac_control u_ctl (
    .sys_clk15     (sys_clk15),
    .n_sys_reset15 (n_sys_reset15),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .acc_ctl       (acc_ctl),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size)
  );

  assign r_num_access = acc_ctl.num_access; // counter seen by sequencer

  // ------------------------------
  // datapaths
  // ------------------------------
  read_assembly u_rd (
    .sys_clk15     (sys_clk15),
    .n_sys_reset15 (n_sys_reset15),
    .acc_ctl       (acc_ctl),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .read_data     (read_data)
  );

  write_lane_select u_wr (
    .acc_ctl    (acc_ctl),
    .write_data (write_data),
    .smc_data   (smc_data)
  );

endmodule

//--- include/tb_smc_mac_tasks.svh
// smc mac test tasks
`ifndef TB_SMC_MAC_TASKS_SVH
`define TB_SMC_MAC_TASKS_SVH

// ------------------------------
// helpers
// ------------------------------
// every task starts and ends just after a falling edge

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected)
  begin
    $display("error: time %0t ns, %s = %h, expected %h", $time, name, actual, expected);
    $display("*** FAILED ***");
    $fatal(1, "value mismatch on %s", name);
  end
endtask

// address cycle, size sampled on the next rising edge
task automatic start_xfer(input xfer_size_t sz);
  valid_access = 1'b1;
  xfer_size    = sz;
  #1;
  check_value("v_xfer_size", 32'(v_xfer_size), 32'(sz)); // live size
  @(negedge sys_clk15);
  valid_access = 1'b0;
endtask

// one smc_done strobe with the given next state
task automatic end_access(input smc_state_t ns);
  smc_done      = 1'b1;
  smc_nextstate = ns;
  @(negedge sys_clk15);
  smc_done      = 1'b0;
  smc_nextstate = smc_idle;
endtask

// read byte on the bus, access ends in the same cycle
task automatic latch_beat(input byte_t b, input smc_state_t ns);
  latch_data    = 1'b1;
  data_smc      = b;
  smc_done      = 1'b1;
  smc_nextstate = ns;
  #1; // read mux settles
endtask

task automatic close_beat();
  @(negedge sys_clk15);
  latch_data    = 1'b0;
  smc_done      = 1'b0;
  smc_nextstate = smc_idle;
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic reset_values();
  word_t wdata;
  wdata = 32'($random(seed));
  check_value("mac_done", 32'(mac_done), 32'd1);
  check_value("r_num_access", 32'(r_num_access), 32'd0);
  check_value("read_data", read_data, 32'd0);
  write_data = wdata; // every lane differs from zero
  #1;
  check_value("smc_data", 32'(smc_data), 32'(wdata[7:0])); // low lane at rest
  @(negedge sys_clk15);
endtask

task automatic byte_xfer();
  word_t wdata;
  byte_t rbyte;
  wdata      = 32'($random(seed));
  rbyte      = 8'($random(seed));
  write_data = wdata;
  start_xfer(xsiz_8);
  check_value("r_num_access", 32'(r_num_access), 32'd0); // single access
  check_value("smc_data", 32'(smc_data), 32'(wdata[7:0]));
  latch_beat(rbyte, smc_idle);
  check_value("read_data", read_data, {rbyte, rbyte, rbyte, rbyte}); // all lanes
  close_beat();
  data_smc = ~rbyte; // bus moves on, value must stay
  #1;
  check_value("read_data", read_data, {rbyte, rbyte, rbyte, rbyte});
endtask

task automatic word_write();
  word_t wdata;
  int    i;
  wdata      = 32'($random(seed));
  write_data = wdata;
  start_xfer(xsiz_32);
  for (i = 3; i >= 0; i--)
  begin
    check_value("r_num_access", 32'(r_num_access), 32'(i));
    check_value("mac_done", 32'(mac_done), (i == 0) ? 32'd1 : 32'd0);
    check_value("smc_data", 32'(smc_data), 32'(wdata[i*8 +: 8])); // msb first
    end_access((i == 0) ? smc_idle : smc_rw); // idle after the last byte
  end
  check_value("mac_done", 32'(mac_done), 32'd1);
  check_value("r_num_access", 32'(r_num_access), 32'd0);
endtask

task automatic word_read();
  byte_t rb [4];
  int    i;
  for (i = 0; i < 4; i++)
    rb[i] = 8'($random(seed));
  start_xfer(xsiz_32);
  for (i = 0; i < 4; i++)
  begin
    latch_beat(rb[i], (i == 3) ? smc_idle : smc_rw);
    if (i == 3)
      check_value("read_data", read_data, {rb[0], rb[1], rb[2], rb[3]}); // live low byte
    close_beat();
  end
  data_smc = ~rb[3];
  #1;
  check_value("read_data", read_data, {rb[0], rb[1], rb[2], rb[3]}); // held word
endtask

task automatic half_read();
  byte_t hi;
  byte_t lo;
  hi = 8'($random(seed));
  lo = 8'($random(seed));
  start_xfer(xsiz_16);
  xfer_size = xsiz_32; // bus size lines move on after the address cycle
  #1;
  check_value("v_xfer_size", 32'(v_xfer_size), 32'(xsiz_16)); // stored size now
  check_value("r_num_access", 32'(r_num_access), 32'd1);
  latch_beat(hi, smc_rw); // msb comes first
  close_beat();
  latch_beat(lo, smc_idle);
  check_value("read_data", read_data, {hi, lo, hi, lo});
  close_beat();
  data_smc = ~lo;
  #1;
  check_value("read_data", read_data, {hi, lo, hi, lo}); // both halves
  check_value("v_xfer_size", 32'(v_xfer_size), 32'(xsiz_16));
endtask

task automatic hold_rule();
  start_xfer(xsiz_32);
  check_value("r_num_access", 32'(r_num_access), 32'd3);
  end_access(smc_store); // no decrement
  check_value("r_num_access", 32'(r_num_access), 32'd3);
  end_access(smc_idle);
  check_value("r_num_access", 32'(r_num_access), 32'd3);
  end_access(smc_rw);    // counts again
  check_value("r_num_access", 32'(r_num_access), 32'd2);
  end_access(smc_rw);
  end_access(smc_rw);
  check_value("mac_done", 32'(mac_done), 32'd1);
endtask

`endif

//--- verification/tb_smc_mac.sv
// smc mac testbench
`timescale 1ns/1ps

module tb_smc_mac;

  import smc_mac_pkg::*;

  // ------------------------------
  // timing
  // ------------------------------
  localparam int CLK_PERIOD  = 10;                          // ns
  localparam int TEST_CYCLES = 48;                          // reset plus all tests
  localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 4; // generous margin

  logic        sys_clk15;
  logic        n_sys_reset15;

  // dut inputs
  logic        valid_access;
  xfer_size_t  xfer_size;
  logic        smc_done;
  smc_state_t  smc_nextstate;
  logic        latch_data;
  byte_t       data_smc;
  word_t       write_data;

  // dut outputs
  access_cnt_t r_num_access;
  logic        mac_done;
  xfer_size_t  v_xfer_size;
  word_t       read_data;
  byte_t       smc_data;

  integer      seed; // shared by every $random call

  smc_mac_top dut0 (
    .sys_clk15     (sys_clk15),
    .n_sys_reset15 (n_sys_reset15),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size),
    .read_data     (read_data),
    .smc_data      (smc_data)
  );

  `include "tb_smc_mac_tasks.svh"

  always #(CLK_PERIOD / 2) sys_clk15 = ~sys_clk15; // 10 ns clock

  // ------------------------------
  // watchdog
  // ------------------------------
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: test sequence did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    seed          = 32'h32fd_5698;
    sys_clk15     = 1'b0;
    n_sys_reset15 = 1'b0;     // reset from time zero
    valid_access  = 1'b0;
    xfer_size     = xsiz_8;
    smc_done      = 1'b0;
    smc_nextstate = smc_idle;
    latch_data    = 1'b0;
    data_smc      = '0;
    write_data    = '0;
    repeat (2) @(negedge sys_clk15);
    n_sys_reset15 = 1'b1;     // released away from the rising edge

    reset_values();
    byte_xfer();
    word_write();
    word_read();
    half_read();
    hold_rule();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
rtl/smc_mac_pkg.sv
rtl/mac_control.sv
rtl/read_assembly.sv
rtl/write_lane_select.sv
rtl/smc_mac_top.sv
verification/tb_smc_mac.sv

//--- run_sim.sh
#!/bin/sh
# build the smc mac testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_smc_mac \
  -f filelist.f -o sim_smc_mac &&
{ out=$(./obj_dir/sim_smc_mac 2>&1); printf '%s\n' "$out";
  printf '%s\n' "$out" | grep -qF '*** PASSED ***'; } &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
